// ==== Makefile ====
TOP = tb_hidden_layer_ctrl
SOURCES = $(shell grep -v '^+' hidden_layer_ctrl.f)

.PHONY: run check clean

obj_dir/V%: $(SOURCES) hidden_layer_ctrl.f
	verilator --binary --timing --assert -Wno-fatal --top-module $* -f hidden_layer_ctrl.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1
	cat sim.log
	$(MAKE) --no-print-directory check

check:
	@test -f sim.log || (echo "sim.log is missing, run the simulation first"; exit 1)
	@if grep -qF '** FAIL **' sim.log; then echo "Failure reported in sim.log"; exit 1; fi
	@echo "No failure reported in sim.log"

clean:
	rm -rf obj_dir sim.log

// ==== hidden_layer_ctrl.f ====
src/nn_layer_pkg.sv
src/cycle_sequencer.sv
src/read_addr_gen.sv
src/act_mem_ctrl.sv
src/del_mem_ctrl.sv
src/hidden_layer_ctrl.sv
test/hidden_layer_ctrl_assertions.sv
test/tb_hidden_layer_ctrl.sv

// ==== src/act_mem_ctrl.sv ====
`timescale 1ns/100ps

module act_mem_ctrl
	import nn_layer_pkg::*;
(
	input  logic       clk,
	input  logic       rst_i,
	input  cycle_idx_t cycle_index_i, // Clock position inside the current cycle
	input  logic       cycle_pulse_i, // Last clock of a cycle
	input  lane_addr_t r_addr_i, // Rotated read addresses for the collections that are read
	input  part_data_t act_i, // Activations for the part being filled
	input  part_data_t adot_i, // Matching activation derivatives
	output lane_addr_t [COLLECTION-1:0] act_addr_o, // Lane addresses per collection
	output lane_we_t [COLLECTION-1:0] act_we_o, // Lane write enables per collection
	output data_t [COLLECTION-1:0][Z-1:0] act_data_o, // Write data for the activation memories
	output data_t [COLLECTION-1:0][Z-1:0] adot_data_o, // Write data for the derivative memories
	output coll_ptr_t rff_ptr_o, // Collection read for feed-forward of the next layer
	output coll_ptr_t wff_ptr_o, // Collection being written by the previous layer
	output coll_ptr_t rup_ptr_o // Collection read for the update and for this layer's backprop
);

	cycle_idx_t idx_d1; // Cycle index one clock late
	cycle_idx_t idx_d2; // Cycle index two clocks late, lines up with the delayed data
	part_data_t act_d1; // Activations one clock late
	part_data_t act_d2; // Activations two clocks late, written together with idx_d2
	part_data_t adot_d1;
	part_data_t adot_d2;
	mem_addr_t  w_row; // Row of the write collection being filled
	logic       w_active; // A working clock reaches the write side

	// Step a collection pointer forward with wrap at COLLECTION
	function automatic coll_ptr_t ptr_next(input coll_ptr_t ptr);
		return (ptr == coll_ptr_t'(COLLECTION - 1)) ? '0 : ptr + coll_ptr_t'(1);
	endfunction

	// The three pointers rotate together and always stay one and two apart
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			rff_ptr_o <= coll_ptr_t'(0);
			wff_ptr_o <= coll_ptr_t'(1);
			rup_ptr_o <= coll_ptr_t'(2);
		end
		else if (cycle_pulse_i)
		begin
			rff_ptr_o <= ptr_next(rff_ptr_o); // New collections show up on the first clock of the next cycle
			wff_ptr_o <= ptr_next(wff_ptr_o);
			rup_ptr_o <= ptr_next(rup_ptr_o);
		end
	end

	// Reset parks the delay line on a drain clock so nothing is written until the first real index arrives
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			idx_d1 <= cycle_idx_t'(CPC - 1);
			idx_d2 <= cycle_idx_t'(CPC - 1);
		end
		else
		begin
			idx_d1 <= cycle_index_i;
			idx_d2 <= idx_d1;
		end
	end

	// Part data takes the same two clocks as the index so each part lands with its own enables
	always_ff @(posedge clk)
	begin
		act_d1  <= act_i;
		act_d2  <= act_d1;
		adot_d1 <= adot_i;
		adot_d2 <= adot_d1;
	end

	assign w_row    = mem_addr_t'(idx_d2 / FO); // Same row for every part, FO clocks in a row
	assign w_active = (idx_d2 < CLOCKS_USED); // Last two clocks only drain

	genvar c, p, k;
	generate
		for (c = 0; c < COLLECTION; c = c + 1)
		begin : g_coll
			logic is_wff; // This collection is the one being written

			assign is_wff = (coll_ptr_t'(c) == wff_ptr_o);

			// Reads do not disturb a collection, so everything except the write side follows r_addr_i
			assign act_addr_o[c] = is_wff ? {Z{w_row}} : r_addr_i;

			for (p = 0; p < FO; p = p + 1)
			begin : g_part
				for (k = 0; k < LANES_PER_PART; k = k + 1)
				begin : g_lane
					// Parts are filled one after the other, the low index bits pick the part
					assign act_we_o[c][p*LANES_PER_PART + k] =
						w_active && (idx_d2 % FO == p) && is_wff;
					assign act_data_o[c][p*LANES_PER_PART + k]  = act_d2[k*WIDTH +: WIDTH];
					assign adot_data_o[c][p*LANES_PER_PART + k] = adot_d2[k*WIDTH +: WIDTH];
				end
			end
		end
	endgenerate

endmodule

// ==== src/cycle_sequencer.sv ====
`timescale 1ns/100ps

module cycle_sequencer
	import nn_layer_pkg::*;
(
	input  logic       clk,
	input  logic       rst_i,
	input  logic       run_i, // Request to keep processing cycles going
	output cycle_idx_t cycle_index_o, // Clock position inside the current cycle
	output logic       cycle_pulse_o // Marks the last clock of a cycle
);

	seq_state_t state; // Current sequencer state
	seq_state_t state_next;

	// The run request is only looked at on index 0 so a started cycle always runs to its end
	always_comb
	begin
		state_next = state;
		case (state)
			SEQ_IDLE:
				if (run_i)
					state_next = SEQ_RUN; // Leave idle and start counting right away
			SEQ_RUN:
				if (cycle_index_o == '0 && !run_i)
					state_next = SEQ_IDLE; // Park at the boundary
			default:
				state_next = SEQ_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			state         <= SEQ_IDLE;
			cycle_index_o <= '0;
		end
		else
		begin
			state <= state_next;
			if (state_next == SEQ_RUN) // Index holds at zero while parked
				cycle_index_o <= (cycle_index_o == cycle_idx_t'(CPC - 1)) ? '0 :
					cycle_index_o + cycle_idx_t'(1);
		end
	end

	assign cycle_pulse_o = (cycle_index_o == cycle_idx_t'(CPC - 1)); // Only reached while running

endmodule

// ==== src/del_mem_ctrl.sv ====
`timescale 1ns/100ps

module del_mem_ctrl
	import nn_layer_pkg::*;
(
	input  logic       clk,
	input  logic       rst_i,
	input  cycle_idx_t cycle_index_i, // Clock position inside the current cycle
	input  logic       cycle_pulse_i, // Last clock of a cycle
	input  lane_addr_t r_addr_i, // Rotated read addresses for the read-modify-write side
	output lane_addr_t [1:0] del_addr_a_o, // Port A lane addresses per delta collection
	output lane_addr_t [1:0] del_addr_b_o, // Port B lane addresses per delta collection
	output lane_we_t [1:0] del_we_a_o, // Port A lane write enables
	output lane_we_t [1:0] del_we_b_o, // Port B lane write enables
	output logic       rbp_ptr_o // Collection read out in sequence for the previous layer
);

	cycle_idx_t idx_d1; // Cycle index one clock late
	lane_addr_t r_addr_d1; // Read address one clock late, becomes the write-back address
	lane_addr_t seq_addr; // Sequential row read on the backprop side
	lane_addr_t clr_addr; // Same row one clock later, cleared behind the read
	logic       rmw_we; // Write-back window of the read-modify-write

	// Only one bit, the two collections simply swap roles every cycle
	always_ff @(posedge clk)
	begin
		if (rst_i)
			rbp_ptr_o <= 1'b0;
		else if (cycle_pulse_i)
			rbp_ptr_o <= ~rbp_ptr_o;
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
			idx_d1 <= cycle_idx_t'(CPC - 1); // Drain clock, so no clear follows reset
		else
			idx_d1 <= cycle_index_i;
	end

	always_ff @(posedge clk)
	begin
		r_addr_d1 <= r_addr_i; // Partial sums come back one clock after the read
	end

	assign seq_addr = {Z{mem_addr_t'(cycle_index_i / FO)}};
	assign clr_addr = {Z{mem_addr_t'(idx_d1 / FO)}};

	// Index 1 to CLOCKS_USED covers the delayed working clocks 0 to CLOCKS_USED-1
	assign rmw_we = (cycle_index_i != '0) && (cycle_index_i <= CLOCKS_USED);

	genvar c, p, k;
	generate
		for (c = 0; c < 2; c = c + 1)
		begin : g_coll
			logic is_rbp; // This collection feeds the previous layer this cycle

			assign is_rbp = (rbp_ptr_o == 1'(c));

			// Backprop side reads on A and clears on B, the other side reads on B and writes back on A
			assign del_addr_a_o[c] = is_rbp ? seq_addr : r_addr_d1;
			assign del_addr_b_o[c] = is_rbp ? clr_addr : r_addr_i;
			assign del_we_a_o[c]   = {Z{rmw_we && !is_rbp}}; // Every lane accumulates at once

			for (p = 0; p < FO; p = p + 1)
			begin : g_part
				for (k = 0; k < LANES_PER_PART; k = k + 1)
				begin : g_lane
					// Clearing goes part by part so that exactly CLOCKS_USED clears are issued
					assign del_we_b_o[c][p*LANES_PER_PART + k] =
						is_rbp && (idx_d1 < CLOCKS_USED) && (idx_d1 % FO == p);
				end
			end
		end
	endgenerate

endmodule

// ==== src/hidden_layer_ctrl.sv ====
`timescale 1ns/100ps

module hidden_layer_ctrl
	import nn_layer_pkg::*;
(
	input  logic       clk,
	input  logic       rst_i,
	input  logic       run_i, // Keep processing cycles running
	input  part_data_t act_i, // Activations from the previous layer
	input  part_data_t adot_i, // Activation derivatives from the previous layer
	output lane_addr_t [COLLECTION-1:0] act_addr_o,
	output lane_we_t [COLLECTION-1:0] act_we_o,
	output data_t [COLLECTION-1:0][Z-1:0] act_data_o,
	output data_t [COLLECTION-1:0][Z-1:0] adot_data_o,
	output lane_addr_t [1:0] del_addr_a_o,
	output lane_addr_t [1:0] del_addr_b_o,
	output lane_we_t [1:0] del_we_a_o,
	output lane_we_t [1:0] del_we_b_o,
	output coll_ptr_t  rff_ptr_o, // Feed-forward read pointer, aligned with the memory read data
	output coll_ptr_t  rup_ptr_o, // Update read pointer, aligned the same way
	output logic       rbp_ptr_o, // Delta collection read out for the previous layer
	output cycle_idx_t cycle_index_o // Clock position inside the current cycle
);

	logic       cycle_pulse; // Last clock of each cycle
	lane_addr_t r_addr; // Rotated read addresses shared by both controllers
	coll_ptr_t  rff_ptr; // Pointers straight from the activation controller
	coll_ptr_t  wff_ptr; // Write collection, the one the previous layer is filling
	coll_ptr_t  rup_ptr;

	cycle_sequencer cycle_sequencer_i (
		.clk           (clk),
		.rst_i         (rst_i),
		.run_i         (run_i),
		.cycle_index_o (cycle_index_o),
		.cycle_pulse_o (cycle_pulse)
	);

	read_addr_gen read_addr_gen_i (
		.cycle_index_i (cycle_index_o),
		.r_addr_o      (r_addr)
	);

	act_mem_ctrl act_mem_ctrl_i (
		.clk           (clk),
		.rst_i         (rst_i),
		.cycle_index_i (cycle_index_o),
		.cycle_pulse_i (cycle_pulse),
		.r_addr_i      (r_addr),
		.act_i         (act_i),
		.adot_i        (adot_i),
		.act_addr_o    (act_addr_o),
		.act_we_o      (act_we_o),
		.act_data_o    (act_data_o),
		.adot_data_o   (adot_data_o),
		.rff_ptr_o     (rff_ptr),
		.wff_ptr_o     (wff_ptr),
		.rup_ptr_o     (rup_ptr)
	);

	del_mem_ctrl del_mem_ctrl_i (
		.clk           (clk),
		.rst_i         (rst_i),
		.cycle_index_i (cycle_index_o),
		.cycle_pulse_i (cycle_pulse),
		.r_addr_i      (r_addr),
		.del_addr_a_o  (del_addr_a_o),
		.del_addr_b_o  (del_addr_b_o),
		.del_we_a_o    (del_we_a_o),
		.del_we_b_o    (del_we_b_o),
		.rbp_ptr_o     (rbp_ptr_o)
	);

	// Memory read data comes out one clock after the address, so the pointers that pick it lag by one
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			rff_ptr_o <= coll_ptr_t'(0); // Same start values as the internal pointers
			rup_ptr_o <= coll_ptr_t'(2);
		end
		else
		begin
			rff_ptr_o <= rff_ptr;
			rup_ptr_o <= rup_ptr;
		end
	end

endmodule

// ==== src/nn_layer_pkg.sv ====
package nn_layer_pkg;

	// Layer geometry
	localparam int P     = 8; // Neurons in the previous layer
	localparam int Z     = 4; // Memory lanes in one collection
	localparam int FO    = 2; // Fan-out, equal to the number of parts per collection
	localparam int L     = 3; // Total number of layers
	localparam int H     = 1; // Index of this hidden layer
	localparam int WIDTH = 16; // Width of one activation or derivative

	// Derived counts
	localparam int MEM_DEPTH      = P / Z; // Entries held by each lane memory
	localparam int CLOCKS_USED    = MEM_DEPTH * FO; // Clocks that carry work in one cycle
	localparam int CPC            = CLOCKS_USED + 2; // Two extra clocks drain the pipeline
	localparam int COLLECTION     = 2 * (L - H) - 1; // Activation collections in flight
	localparam int LANES_PER_PART = Z / FO; // Lanes filled together on one clock

	// Position inside a processing cycle
	typedef logic [$clog2(CPC)-1:0] cycle_idx_t;

	// Address of one entry in one lane memory
	typedef logic [$clog2(MEM_DEPTH)-1:0] mem_addr_t;

	// Addresses of all Z lanes packed side by side, lane 0 in the low bits
	typedef logic [Z*$clog2(MEM_DEPTH)-1:0] lane_addr_t;

	typedef logic [$clog2(COLLECTION)-1:0] coll_ptr_t; // Selects one activation collection
	typedef logic [Z-1:0] lane_we_t; // One write enable per lane

	// Data for the lanes of one part, lane 0 in the low bits
	typedef logic [LANES_PER_PART*WIDTH-1:0] part_data_t;

	typedef logic [WIDTH-1:0] data_t;

	// Cycle sequencer states
	typedef enum logic
	{
		SEQ_IDLE,
		SEQ_RUN
	} seq_state_t;

endpackage

// ==== src/read_addr_gen.sv ====
`timescale 1ns/100ps

// Deterministic stand-in for the interleaver and address decoder pair
module read_addr_gen
	import nn_layer_pkg::*;
(
	input  cycle_idx_t cycle_index_i, // Clock position inside the current cycle
	output lane_addr_t r_addr_o // Read address for every lane, lane 0 in the low bits
);

	localparam int AW = $bits(mem_addr_t); // Bits of one lane address

	cycle_idx_t row; // Memory row that the current clock is working on

	// The row moves on once all FO parts of it have been visited
	assign row = cycle_idx_t'(cycle_index_i / FO);

	genvar j;
	generate
		for (j = 0; j < Z; j = j + 1)
		begin : g_lane
			// Each lane starts j rows further on, so one clock touches several rows
			// across the lanes and reads are spread the way the interleaver spread them
			assign r_addr_o[j*AW +: AW] = mem_addr_t'((row + j) % MEM_DEPTH);
		end
	endgenerate

	// On the drain clocks the row runs past MEM_DEPTH and simply wraps
	// The controllers ignore these addresses because no write is enabled then

endmodule

// ==== test/hidden_layer_ctrl_assertions.sv ====
`timescale 1ns/100ps

module hidden_layer_ctrl_assertions
	import nn_layer_pkg::*;
(
	input logic clk,
	input logic rst_i,
	input logic run_i,
	input part_data_t act_i, // Part data as the sender presents it
	input part_data_t adot_i,
	input cycle_idx_t cycle_index_i, // Index straight from the sequencer
	input lane_addr_t [COLLECTION-1:0] act_addr_i,
	input lane_we_t [COLLECTION-1:0] act_we_i,
	input data_t [COLLECTION-1:0][Z-1:0] act_data_i,
	input data_t [COLLECTION-1:0][Z-1:0] adot_data_i,
	input coll_ptr_t rff_i, // Internal pointers of the activation controller
	input coll_ptr_t wff_i,
	input coll_ptr_t rup_i,
	input coll_ptr_t rff_reg_i, // Registered copies on the top level ports
	input coll_ptr_t rup_reg_i,
	input logic rbp_i,
	input lane_addr_t [1:0] del_addr_a_i,
	input lane_addr_t [1:0] del_addr_b_i,
	input lane_we_t [1:0] del_we_a_i,
	input lane_we_t [1:0] del_we_b_i
);

	localparam int AW = $bits(mem_addr_t); // Bits of one lane address
	localparam lane_we_t PART_MASK = lane_we_t'((1 << LANES_PER_PART) - 1); // Lanes of part 0

	int fail_count = 0; // Read back by the testbench at the end of the run
	cycle_idx_t idx_d1;
	cycle_idx_t idx_d2; // Index of the data that is being written now
	logic wrap; // Last clock of a processing cycle
	lane_we_t [COLLECTION-1:0] exp_we;
	lane_addr_t exp_raddr;
	lane_addr_t raddr_d1; // Rotation one clock late, where partial sums are written back
	part_data_t act_d1;
	part_data_t act_d2; // Part data presented two clocks ago
	part_data_t adot_d1;
	part_data_t adot_d2;
	data_t [Z-1:0] exp_act; // Write data that every collection should show
	data_t [Z-1:0] exp_adot;
	lane_we_t [1:0] exp_we_a;
	lane_we_t [1:0] exp_we_b;

	// Pointer step modulo the number of collections
	function automatic coll_ptr_t step_ptr(input coll_ptr_t p);
		return coll_ptr_t'((p + 1) % COLLECTION);
	endfunction

	task automatic note_failure(input string what);
		fail_count++;
		$error("%s", what);
	endtask

	assign wrap = (cycle_index_i == cycle_idx_t'(CPC - 1));

	// Two clock delay of the index, starting on a drain clock so reset writes nothing
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			idx_d1 <= cycle_idx_t'(CPC - 1);
			idx_d2 <= cycle_idx_t'(CPC - 1);
		end
		else
		begin
			idx_d1 <= cycle_index_i;
			idx_d2 <= idx_d1;
		end
	end

	always_ff @(posedge clk)
	begin
		act_d1   <= act_i; // Data presented with index k is written two clocks later
		act_d2   <= act_d1;
		adot_d1  <= adot_i;
		adot_d2  <= adot_d1;
		raddr_d1 <= exp_raddr;
	end

	always_comb
	begin
		exp_we = '0;
		if (idx_d2 < CLOCKS_USED)
			exp_we[wff_i] = PART_MASK << ((idx_d2 % FO) * LANES_PER_PART); // One part per clock
	end

	// Lane j starts j rows further on
	always_comb
	begin
		for (int j = 0; j < Z; j++)
			exp_raddr[j*AW +: AW] = mem_addr_t'(((cycle_index_i / FO) + j) % MEM_DEPTH);
	end

	// Word k of the part data goes to lane k of whichever part is enabled
	always_comb
	begin
		for (int l = 0; l < Z; l++)
		begin
			exp_act[l]  = act_d2[(l % LANES_PER_PART)*WIDTH +: WIDTH];
			exp_adot[l] = adot_d2[(l % LANES_PER_PART)*WIDTH +: WIDTH];
		end
	end

	always_comb
	begin
		exp_we_a = '0;
		exp_we_b = '0;
		if (cycle_index_i != '0 && cycle_index_i <= CLOCKS_USED)
			exp_we_a[!rbp_i] = '1; // All lanes accumulate at once
		if (idx_d1 < CLOCKS_USED)
			exp_we_b[rbp_i] = PART_MASK << ((idx_d1 % FO) * LANES_PER_PART); // Cleared part by part
	end

	a_index_step: assert property (@(posedge clk) disable iff (rst_i)
		cycle_index_i != '0 |=> cycle_index_i == cycle_idx_t'(($past(cycle_index_i) + 1) % CPC))
		else note_failure("Cycle index did not step by one inside a cycle");

	// At a boundary the run request alone decides between starting and parking
	a_index_start: assert property (@(posedge clk) disable iff (rst_i)
		cycle_index_i == '0 |=> cycle_index_i == cycle_idx_t'($past(run_i)))
		else note_failure("Cycle index did not follow the run request at a boundary");

	a_act_we: assert property (@(posedge clk) disable iff (rst_i) act_we_i == exp_we)
		else note_failure("Activation write enables are on the wrong lanes or collection");

	a_write_side: assert property (@(posedge clk) disable iff (rst_i)
		act_we_i != '0 |-> act_addr_i[wff_i] == {Z{mem_addr_t'(idx_d2 / FO)}}
			&& act_data_i == {COLLECTION{exp_act}} && adot_data_i == {COLLECTION{exp_adot}})
		else note_failure("Write address or write data of the activation memories is wrong");

	a_ptr_spacing: assert property (@(posedge clk) disable iff (rst_i)
		wff_i == step_ptr(rff_i) && rup_i == step_ptr(wff_i))
		else note_failure("Activation pointers are not one and two apart");

	a_ptr_advance: assert property (@(posedge clk) disable iff (rst_i)
		1'b1 |=> rff_i == ($past(wrap) ? step_ptr($past(rff_i)) : $past(rff_i)))
		else note_failure("Feed-forward read pointer did not advance once per cycle");

	a_ptr_lag: assert property (@(posedge clk) disable iff (rst_i)
		1'b1 |=> rff_reg_i == $past(rff_i) && rup_reg_i == $past(rup_i))
		else note_failure("Registered read pointers do not lag by one clock");

	a_rbp_toggle: assert property (@(posedge clk) disable iff (rst_i)
		1'b1 |=> rbp_i == ($past(rbp_i) ^ $past(wrap)))
		else note_failure("Delta pointer did not toggle exactly once per cycle");

	// Port A writes back only on the accumulating side, port B clears only behind the read
	a_del_we: assert property (@(posedge clk) disable iff (rst_i)
		del_we_a_i == exp_we_a && del_we_b_i == exp_we_b)
		else note_failure("Delta write enables are set on the wrong collection or clock");

	a_del_addr: assert property (@(posedge clk) disable iff (rst_i)
		del_addr_a_i[rbp_i] == {Z{mem_addr_t'(cycle_index_i / FO)}}
			&& del_addr_b_i[rbp_i] == {Z{mem_addr_t'(idx_d1 / FO)}}
			&& del_addr_a_i[!rbp_i] == raddr_d1 && del_addr_b_i[!rbp_i] == exp_raddr)
		else note_failure("Delta port addresses do not follow the read and clear rows");

	for (genvar c = 0; c < COLLECTION; c++)
	begin : g_read_addr
		a_read_addr: assert property (@(posedge clk) disable iff (rst_i)
			wff_i != coll_ptr_t'(c) |-> act_addr_i[c] == exp_raddr)
			else note_failure($sformatf("Read address of collection %0d breaks the rotation", c));
	end

endmodule

// ==== test/tb_hidden_layer_ctrl.sv ====
`timescale 1ns/100ps

module tb_hidden_layer_ctrl
	import nn_layer_pkg::*;
();

	localparam int RUN_CYCLES = 8 + 1 + 3 + 2; // Running, parked, running again, drain
	localparam int WATCHDOG_NS = RUN_CYCLES * CPC * 4 + 200; // Clock period is 4 ns

	logic clk;
	logic rst_i;
	logic run_i;
	part_data_t act_i;
	part_data_t adot_i;
	lane_addr_t [COLLECTION-1:0] act_addr_o;
	lane_we_t [COLLECTION-1:0] act_we_o;
	data_t [COLLECTION-1:0][Z-1:0] act_data_o;
	data_t [COLLECTION-1:0][Z-1:0] adot_data_o;
	lane_addr_t [1:0] del_addr_a_o;
	lane_addr_t [1:0] del_addr_b_o;
	lane_we_t [1:0] del_we_a_o;
	lane_we_t [1:0] del_we_b_o;
	coll_ptr_t rff_ptr_o;
	coll_ptr_t rup_ptr_o;
	logic rbp_ptr_o;
	cycle_idx_t cycle_index_o;
	logic [15:0] lfsr_state;
	int value_errors;
	int assert_errors;

	hidden_layer_ctrl hidden_layer_ctrl_i (.*);

	bind hidden_layer_ctrl hidden_layer_ctrl_assertions assertions_i (
		.clk           (clk),
		.rst_i         (rst_i),
		.run_i         (run_i),
		.act_i         (act_i),
		.adot_i        (adot_i),
		.cycle_index_i (cycle_index_o),
		.act_addr_i    (act_addr_o),
		.act_we_i      (act_we_o),
		.act_data_i    (act_data_o),
		.adot_data_i   (adot_data_o),
		.rff_i         (rff_ptr),
		.wff_i         (wff_ptr),
		.rup_i         (rup_ptr),
		.rff_reg_i     (rff_ptr_o),
		.rup_reg_i     (rup_ptr_o),
		.rbp_i         (rbp_ptr_o),
		.del_addr_a_i  (del_addr_a_o),
		.del_addr_b_i  (del_addr_b_o),
		.del_we_a_i    (del_we_a_o),
		.del_we_b_i    (del_we_b_o)
	);

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_part(output part_data_t v);
		for (int b = 0; b < $bits(part_data_t); b++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v[b] = lfsr_state[0]; // One step for every bit taken
		end
	endtask

	// Returns on the edge that samples the last clock of the n-th cycle
	task automatic wait_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			while (cycle_index_o != cycle_idx_t'(CPC - 1))
				@(posedge clk);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		part_data_t a;
		part_data_t d;
		draw_part(a);
		draw_part(d);
		act_i  <= a; // Fresh part data on every clock
		adot_i <= d;
	end

	initial
	begin
		lfsr_state    = 16'd38504;
		value_errors  = 0;
		rst_i         = 1'b1;
		run_i         = 1'b0;
		act_i         = '0;
		adot_i        = '0;
		repeat (3)
			@(posedge clk);
		rst_i <= 1'b0;
		run_i <= 1'b1;
		wait_cycles(8);
		run_i <= 1'b0; // Seen low at the next index 0, so the sequencer parks
		repeat (CPC)
			@(posedge clk);
		run_i <= 1'b1;
		wait_cycles(3);
		run_i <= 1'b0;
		repeat (2 * CPC)
			@(negedge clk);
		if (cycle_index_o !== '0)
		begin
			value_errors++;
			$display("[ERROR] %0t cycle_index_o expected 0 got %0d", $time, cycle_index_o);
		end
		assert_errors = hidden_layer_ctrl_i.assertions_i.fail_count;
		$display("Run finished with %0d wrong values and %0d assertion failures",
			value_errors, assert_errors);
		if (value_errors == 0 && assert_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin
		#WATCHDOG_NS;
		$display("Timeout: the run did not end within %0d ns", WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

endmodule
